/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_fifo_arbiter
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
arb_pkg.sv
token_source.sv
token_fifo.sv
starvation_free_arbiter.sv
dual_fifo_arbiter.sv
seven_segment_display.sv
fifo_arbiter_board_top.sv
tb_fifo_arbiter.sv

/* arb_pkg.sv */
package arb_pkg;

    // --------------------
    // Sizes and rates

    localparam token_width         = 4;
    localparam fifo_depth          = 4;
    localparam fifo_ptr_width      = 2;  // log2 of fifo_depth
    localparam digit_count         = 4;
    localparam starve_limit        = 3;  // A wins in a row while B waits
    localparam refresh_cycles_log2 = 4;

    // Status digit, segment order is a b c d e f g h
    localparam status_digit  = 1;
    localparam seg_ready_a   = 8'b0000_0001;  // Dot
    localparam seg_ready_b   = 8'b0000_0010;  // Segment g
    localparam seg_ready_out = 8'b0001_0000;  // Segment d

    // --------------------
    // Types

    typedef logic [token_width - 1:0] token_t;
    typedef logic [token_width - 2:0] count_t;
    typedef logic [7:0]               segments_t;
    typedef logic [digit_count - 1:0] digit_sel_t;
    typedef logic [1:0]               win_count_t;

    // Forward half of a valid/ready stream
    typedef struct packed {
        logic   valid;
        token_t data;
    } stream_t;

    typedef enum logic {
        grant_a,
        grant_b
    } grant_e;

endpackage

/* dual_fifo_arbiter.sv */
`timescale 1ns/1ps

module dual_fifo_arbiter
(
    input  logic             clk,
    input  logic             reset,
    input  arb_pkg::stream_t a,
    output logic             a_ready,
    input  arb_pkg::stream_t b,
    output logic             b_ready,
    output arb_pkg::stream_t out,
    input  logic             out_ready
);

    // FIFO heads into the arbiter
    arb_pkg::stream_t a_head;
    arb_pkg::stream_t b_head;
    logic             a_head_ready;
    logic             b_head_ready;

    // One buffer per source so a stalled one never blocks the other
    token_fifo a_fifo_inst
    (
        .clk       (clk),
        .reset     (reset),
        .in        (a),
        .in_ready  (a_ready),
        .out       (a_head),
        .out_ready (a_head_ready)
    );

    token_fifo b_fifo_inst
    (
        .clk       (clk),
        .reset     (reset),
        .in        (b),
        .in_ready  (b_ready),
        .out       (b_head),
        .out_ready (b_head_ready)
    );

    starvation_free_arbiter arbiter_inst
    (
        .clk       (clk),
        .reset     (reset),
        .a         (a_head),
        .a_ready   (a_head_ready),
        .b         (b_head),
        .b_ready   (b_head_ready),
        .out       (out),
        .out_ready (out_ready)
    );

endmodule

/* fifo_arbiter_board_top.sv */
`timescale 1ns/1ps

module fifo_arbiter_board_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic [2:0]          key,
    input  logic [0:0]          sw,
    output logic [7:0]          led,
    output arb_pkg::segments_t  abcdefgh,
    output arb_pkg::digit_sel_t digit
);

    arb_pkg::stream_t a_stream;
    arb_pkg::stream_t b_stream;
    arb_pkg::stream_t out_stream;

    logic a_ready;
    logic b_ready;
    logic out_ready;

    arb_pkg::segments_t status;

    assign out_ready = ~sw[0];  // Switch off means ready

    // --------------------
    // Sources and arbitration

    token_source #(.tag(1'b0)) a_source_inst
    (
        .clk       (clk),
        .reset     (reset),
        .enable    (key[2]),
        .out       (a_stream),
        .out_ready (a_ready)
    );

    token_source #(.tag(1'b1)) b_source_inst
    (
        .clk       (clk),
        .reset     (reset),
        .enable    (key[1]),
        .out       (b_stream),
        .out_ready (b_ready)
    );

    dual_fifo_arbiter dual_fifo_arbiter_inst
    (
        .clk       (clk),
        .reset     (reset),
        .a         (a_stream),
        .a_ready   (a_ready),
        .b         (b_stream),
        .b_ready   (b_ready),
        .out       (out_stream),
        .out_ready (out_ready)
    );

    // --------------------
    // LEDs and display

    assign led = {out_ready, b_ready, a_ready, out_stream.valid, out_stream.data};

    always_comb
    begin
        status = '0;
        if (a_ready)
            status |= arb_pkg::seg_ready_a;
        if (b_ready)
            status |= arb_pkg::seg_ready_b;
        if (out_ready)
            status |= arb_pkg::seg_ready_out;
    end

    seven_segment_display display_inst
    (
        .clk      (clk),
        .reset    (reset),
        .number   ({a_stream.data, b_stream.data, 4'h0, out_stream.data}),
        .blank    ({3'b000, ~out_stream.valid}),  // No output token, dark digit 0
        .status   (status),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

/* seven_segment_display.sv */
`timescale 1ns/1ps

module seven_segment_display
(
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [arb_pkg::digit_count * 4 - 1:0]       number,
    input  arb_pkg::digit_sel_t                         blank,
    input  arb_pkg::segments_t                          status,
    output arb_pkg::segments_t                          abcdefgh,
    output arb_pkg::digit_sel_t                         digit
);

    logic [arb_pkg::refresh_cycles_log2 - 1:0] refresh_cnt;

    arb_pkg::token_t    nibble;
    arb_pkg::segments_t font;

    // --------------------
    // Digit rotation

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            refresh_cnt <= '0;
            digit       <= arb_pkg::digit_sel_t'(1);  // Digit 0 first
        end
        else
        begin
            refresh_cnt <= refresh_cnt + 1'b1;
            if (refresh_cnt == '1)
                digit <= {digit[arb_pkg::digit_count - 2:0], digit[arb_pkg::digit_count - 1]};
        end
    end

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < arb_pkg::digit_count; i++)
            if (digit[i])
                nibble = number[i * 4 +: 4];
    end

    // Hex font, a in the top bit
    always_comb
    begin
        case (nibble)
            4'h0: font = 8'b1111_1100;
            4'h1: font = 8'b0110_0000;
            4'h2: font = 8'b1101_1010;
            4'h3: font = 8'b1111_0010;
            4'h4: font = 8'b0110_0110;
            4'h5: font = 8'b1011_0110;
            4'h6: font = 8'b1011_1110;
            4'h7: font = 8'b1110_0000;
            4'h8: font = 8'b1111_1110;
            4'h9: font = 8'b1111_0110;
            4'ha: font = 8'b1110_1110;
            4'hb: font = 8'b0011_1110;
            4'hc: font = 8'b1001_1100;
            4'hd: font = 8'b0111_1010;
            4'he: font = 8'b1001_1110;
            default: font = 8'b1000_1110;  // f
        endcase
    end

    // --------------------
    // Segment output

    always_comb
    begin
        if ((digit & blank) != '0)
            abcdefgh = '0;
        else if (digit[arb_pkg::status_digit])
            abcdefgh = status;  // Status digit replaces its nibble
        else
            abcdefgh = font;
    end

endmodule

/* starvation_free_arbiter.sv */
`timescale 1ns/1ps

module starvation_free_arbiter
(
    input  logic             clk,
    input  logic             reset,
    input  arb_pkg::stream_t a,
    output logic             a_ready,
    input  arb_pkg::stream_t b,
    output logic             b_ready,
    output arb_pkg::stream_t out,
    input  logic             out_ready
);

    arb_pkg::grant_e     grant_sel;
    arb_pkg::grant_e     last_grant;
    arb_pkg::win_count_t win_count;

    logic b_starving;
    logic a_xfer;
    logic b_xfer;

    assign b_starving = (win_count == arb_pkg::win_count_t'(arb_pkg::starve_limit));

    // --------------------
    // Grant selection

    always_comb
    begin
        if (a.valid && b.valid)
            grant_sel = b_starving ? arb_pkg::grant_b : arb_pkg::grant_a;
        else if (a.valid)
            grant_sel = arb_pkg::grant_a;
        else if (b.valid)
            grant_sel = arb_pkg::grant_b;
        else
            grant_sel = last_grant;  // Idle, keep pointing at the last winner
    end

    assign out.valid = a.valid || b.valid;
    assign out.data  = (grant_sel == arb_pkg::grant_b) ? b.data : a.data;

    assign a_ready = out_ready && (grant_sel == arb_pkg::grant_a);
    assign b_ready = out_ready && (grant_sel == arb_pkg::grant_b);

    assign a_xfer = a.valid && a_ready;
    assign b_xfer = b.valid && b_ready;

    // --------------------
    // Win counter and last winner

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            win_count  <= '0;
            last_grant <= arb_pkg::grant_a;
        end
        else
        begin
            if (b_xfer || !b.valid)
                win_count <= '0;
            else if (a_xfer)
                win_count <= win_count + 1'b1;  // A beat a waiting B

            if (a_xfer)
                last_grant <= arb_pkg::grant_a;
            else if (b_xfer)
                last_grant <= arb_pkg::grant_b;
        end
    end

    one_ready_at_a_time: assert property (@(posedge clk) disable iff (reset)
        !(a_ready && b_ready));

    // Once the limit is hit, the next transfer goes to B
    b_served_at_limit: assert property (@(posedge clk) disable iff (reset)
        b.valid && b_starving && out_ready |=> win_count == '0);

endmodule

/* tb_fifo_arbiter.sv */
`timescale 1ns/1ps

module tb_fifo_arbiter;

    localparam int reset_cycles  = 16;
    localparam int random_cycles = 1000;
    localparam int hold_cycles   = 300;   // Output blocked with both keys down
    localparam int busy_cycles   = 300;   // Output open with both keys down
    localparam int tail_cycles   = 1400;
    localparam int stim_cycles   = random_cycles + hold_cycles + busy_cycles + tail_cycles;
    localparam int cycle_limit   = reset_cycles + stim_cycles + 200;

    logic                clk;
    logic                reset;
    logic [2:0]          key;
    logic [0:0]          sw;
    logic [7:0]          led;
    arb_pkg::segments_t  abcdefgh;
    arb_pkg::digit_sel_t digit;

    // Reference model state
    arb_pkg::token_t a_queue [$];
    arb_pkg::token_t b_queue [$];
    arb_pkg::count_t a_count;
    arb_pkg::count_t b_count;
    int              win_count;
    logic            exp_valid;
    logic            exp_grant_b;
    logic            exp_a_ready;
    logic            exp_b_ready;

    logic [15:0] lfsr;
    int          token_errors;
    int          flag_errors;
    int          segment_errors;
    int          other_errors;
    int          forced_b;
    int          cycle_count;

    fifo_arbiter_board_top fifo_arbiter_board_top_inst
    (
        .clk      (clk),
        .reset    (reset),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Random bits

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[6:0], lfsr[15]};
            lfsr  = lfsr_next(lfsr);  // One step per bit
        end
    endtask

    // --------------------
    // Compare tasks

    task check_token(input string what, input arb_pkg::token_t got, input arb_pkg::token_t exp);
        if (got !== exp)
        begin
            token_errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            flag_errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task check_segments(input string what, input arb_pkg::segments_t got,
                        input arb_pkg::segments_t exp);
        if (got !== exp)
        begin
            segment_errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // --------------------
    // Reference model

    task predict();
        exp_a_ready = a_queue.size() < arb_pkg::fifo_depth;
        exp_b_ready = b_queue.size() < arb_pkg::fifo_depth;
        exp_valid   = (a_queue.size() != 0) || (b_queue.size() != 0);
        if (a_queue.size() != 0 && b_queue.size() != 0)
            exp_grant_b = (win_count == arb_pkg::starve_limit);  // A first unless B starves
        else
            exp_grant_b = (b_queue.size() != 0);
    endtask

    task check_outputs();
        arb_pkg::segments_t exp_status;
        exp_status = 8'h00;
        if (exp_a_ready)
            exp_status |= 8'h01;  // Dot
        if (exp_b_ready)
            exp_status |= 8'h02;  // Segment g
        if (!sw[0])
            exp_status |= 8'h10;  // Segment d
        check_flag("A ready", led[5], exp_a_ready);
        check_flag("B ready", led[6], exp_b_ready);
        check_flag("output ready", led[7], ~sw[0]);
        check_flag("output valid", led[4], exp_valid);
        if (exp_valid)
            check_token("output token", led[3:0], exp_grant_b ? b_queue[0] : a_queue[0]);
        // B token leaving the DUT while A still waits
        if (led[4] && led[7] && led[3] && a_queue.size() != 0)
            forced_b++;
        check_flag("digit select one-hot", $onehot(digit), 1'b1);
        if (digit == 4'b0010)
            check_segments("status digit", abcdefgh, exp_status);
        if (digit == 4'b0001 && !exp_valid)
            check_segments("blank digit 0", abcdefgh, 8'h00);
    endtask

    // Transfers of the coming rising edge
    task advance_model(input logic a_key, input logic b_key, input logic out_ready);
        logic a_xfer;
        logic b_xfer;
        a_xfer = exp_valid && out_ready && !exp_grant_b;
        b_xfer = exp_valid && out_ready && exp_grant_b;
        if (b_xfer || b_queue.size() == 0)
            win_count = 0;
        else if (a_xfer)
            win_count++;
        if (a_xfer)
            void'(a_queue.pop_front());
        if (b_xfer)
            void'(b_queue.pop_front());
        if (a_key && exp_a_ready)
        begin
            a_queue.push_back({1'b0, a_count});
            a_count++;
        end
        if (b_key && exp_b_ready)
        begin
            b_queue.push_back({1'b1, b_count});
            b_count++;
        end
    endtask

    // --------------------
    // Stimulus

    task run_cycle(input logic [2:0] key_val, input logic sw_val);
        @(negedge clk);
        key   = key_val;
        sw[0] = sw_val;
        #2;  // Outputs settled well before the next rising edge
        predict();
        check_outputs();
        advance_model(key_val[2], key_val[1], ~sw_val);
    endtask

    task random_cycle();
        logic [7:0] bits;
        draw_bits(5, bits);
        run_cycle(bits[2:0], bits[3] & bits[4]);  // Switch on a quarter of the time
    endtask

    initial
    begin
        key            = 3'b000;
        sw             = 1'b0;
        reset          = 1'b1;
        lfsr           = 16'd61822;
        a_count        = '0;
        b_count        = '0;
        win_count      = 0;
        token_errors   = 0;
        flag_errors    = 0;
        segment_errors = 0;
        other_errors   = 0;
        forced_b       = 0;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #2;
        check_flag("output valid after reset", led[4], 1'b0);
        check_flag("A ready after reset", led[5], 1'b1);
        check_flag("B ready after reset", led[6], 1'b1);

        repeat (random_cycles) random_cycle();

        repeat (hold_cycles) run_cycle(3'b110, 1'b1);
        check_flag("A ready with full FIFO", led[5], 1'b0);
        check_flag("B ready with full FIFO", led[6], 1'b0);

        repeat (busy_cycles) run_cycle(3'b110, 1'b0);
        repeat (tail_cycles) random_cycle();

        if (forced_b == 0)
        begin
            other_errors++;
            $display("The DUT never sent a B token while A was waiting");
        end

        @(negedge clk);
        $display("Errors: %0d token, %0d flag, %0d segment, %0d other",
                 token_errors, flag_errors, segment_errors, other_errors);
        if (token_errors + flag_errors + segment_errors + other_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // --------------------
    // Timeout

    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the stimulus did not complete", cycle_count);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* token_fifo.sv */
`timescale 1ns/1ps

module token_fifo
(
    input  logic             clk,
    input  logic             reset,
    input  arb_pkg::stream_t in,
    output logic             in_ready,
    output arb_pkg::stream_t out,
    input  logic             out_ready
);

    // Pointers carry one extra wrap bit
    logic [arb_pkg::fifo_ptr_width:0] wr_ptr;
    logic [arb_pkg::fifo_ptr_width:0] rd_ptr;
    logic [arb_pkg::fifo_ptr_width:0] count;

    arb_pkg::token_t mem [arb_pkg::fifo_depth];

    logic empty;
    logic full;
    logic push;
    logic pop;

    // --------------------
    // Status

    assign empty = (wr_ptr == rd_ptr);

    // Same slot, different lap
    assign full  = (wr_ptr[arb_pkg::fifo_ptr_width - 1:0] == rd_ptr[arb_pkg::fifo_ptr_width - 1:0])
                && (wr_ptr[arb_pkg::fifo_ptr_width] != rd_ptr[arb_pkg::fifo_ptr_width]);

    assign count = wr_ptr - rd_ptr;

    assign in_ready  = !full;
    assign out.valid = !empty;
    assign out.data  = mem[rd_ptr[arb_pkg::fifo_ptr_width - 1:0]];

    assign push = in.valid && in_ready;
    assign pop  = out.valid && out_ready;

    // --------------------
    // Pointers and storage

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr[arb_pkg::fifo_ptr_width - 1:0]] <= in.data;
    end

    // --------------------
    // Checks

    // Filling the last slot must close the input on the next cycle
    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        push && !pop && (count == arb_pkg::fifo_depth - 1) |=> !in_ready);

    // A stalled head keeps its token
    head_held_stable: assert property (@(posedge clk) disable iff (reset)
        out.valid && !out_ready |=> out.valid && $stable(out.data));

endmodule

/* token_source.sv */
`timescale 1ns/1ps

module token_source
#(
    parameter bit tag = 1'b0
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,     // Key level
    output arb_pkg::stream_t out,
    input  logic             out_ready
);

    arb_pkg::count_t count;
    logic            accepted;

    assign accepted = out.valid && out_ready;

    // Wraps over the counter width
    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (accepted)
            count <= count + 1'b1;
    end

    // Tag on top, so A gives 0..7 and B gives 8..f
    assign out.valid = enable;
    assign out.data  = {tag, count};

endmodule
